// ==== common/nack_wnd_pkg.sv ====
// nack window manager package: stream, pointer, key and type definitions
`default_nettype none

package nack_wnd_pkg;

    //----------------------------------------------------------------------
    // stream store geometry
    //----------------------------------------------------------------------
    localparam int WND_DEPTH = 1024;            // streams tracked
    localparam int WND_AW    = 10;              // store address width
    localparam int RST_DELAY = 10;              // cycles before the ram sweep

    typedef logic [15:0] sn_t;                  // stream serial number, low 10 bits index
    typedef logic [31:0] ptr_t;                 // window header or tail pointer
    typedef logic [31:0] chksum_t;              // request checksum
    typedef logic [95:0] keymsg_t;              // [63:32] expected rpn, [31:0] rpn

    //----------------------------------------------------------------------
    // encodings
    //----------------------------------------------------------------------
    typedef enum logic [1:0] {
        WND_NORMAL     = 2'b01,                 // plain data packet
        WND_NACK_REPLY = 2'b10,                 // retransmit answer
        WND_RESET      = 2'b11                  // restart the window
    } wnd_type_e;

    typedef enum logic [1:0] {
        ST_RST_WAIT = 2'b00,                    // settle after reset
        ST_INIT     = 2'b01,                    // zero both rams
        ST_RUN      = 2'b10                     // normal traffic
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== wnd_store/wnd_ptr_ram.sv ====
// window pointer ram: 1024 x {hdr, tail}, init sweep write mux, two-cycle read
`default_nettype none

module wnd_ptr_ram
    import nack_wnd_pkg::*;
(
    input  wire logic              sys_clk,
    input  wire logic              sys_rst,
    input  wire logic              i_init_done,
    input  wire logic [WND_AW-1:0] i_init_addr,
    input  wire logic              i_wr_en,
    input  wire logic [WND_AW-1:0] i_wr_addr,
    input  wire ptr_t              i_wr_hdr,
    input  wire ptr_t              i_wr_tail,
    input  wire logic              i_rd_valid,
    input  wire logic [WND_AW-1:0] i_rd_addr,
    output logic                   o_rd_valid,
    output ptr_t                   o_rd_hdr,
    output ptr_t                   o_rd_tail
);

    logic [63:0]       mem [WND_DEPTH];             // {hdr, tail}
    logic              we;
    logic [WND_AW-1:0] wa;
    logic [63:0]       wd;
    logic [63:0]       rd_q;                        // array read stage
    logic [63:0]       out_q;                       // output register
    logic [1:0]        vld_q;

    // sweep owns the write port until init is done
    assign we = i_init_done ? i_wr_en : 1'b1;
    assign wa = i_init_done ? i_wr_addr : i_init_addr;
    assign wd = i_init_done ? {i_wr_hdr, i_wr_tail} : 64'd0;

    always_ff @(posedge sys_clk)
    begin
        if (we)
            mem[wa] <= wd;
        rd_q  <= mem[i_rd_addr];                    // read first on collision
        out_q <= rd_q;
    end

    // read strobe follows the data, dropped during the sweep
    always_ff @(posedge sys_clk)
    begin
        if (sys_rst)
            vld_q <= '0;
        else
            vld_q <= {vld_q[0], i_rd_valid & i_init_done};
    end

    assign o_rd_valid = vld_q[1];
    assign o_rd_hdr   = out_q[63:32];
    assign o_rd_tail  = out_q[31:0];

endmodule

`default_nettype wire

// ==== wnd_store/ot_hitbox.sv ====
// timeout hitbox: one flag per stream, set by timer, cleared by update
`default_nettype none

module ot_hitbox
    import nack_wnd_pkg::*;
(
    input  wire logic  sys_clk,
    input  wire logic  sys_rst,
    input  wire logic  i_set,                       // timer timeout
    input  wire sn_t   i_set_sn,
    input  wire logic  i_clr,                       // window update
    input  wire sn_t   i_clr_sn,
    input  wire sn_t   i_rd_sn,
    output logic       o_timed_out
);

    logic [WND_DEPTH-1:0] flags_q;                  // 1 = stream timed out
    logic [WND_AW-1:0]    set_idx;
    logic [WND_AW-1:0]    clr_idx;
    logic [31:0]          row_q;                    // stage 1 row latch
    logic [4:0]           col_q;                    // bit select, one cycle late
    logic                 hit_q;

    assign set_idx = i_set_sn[WND_AW-1:0];
    assign clr_idx = i_clr_sn[WND_AW-1:0];

    //----------------------------------------------------------------------
    // flag array, set after clear so a timeout wins
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk)
    begin
        if (sys_rst)
            flags_q <= '1;                          // everyone starts timed out
        else
        begin
            if (i_clr)
                flags_q[clr_idx] <= 1'b0;
            if (i_set)
                flags_q[set_idx] <= 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // two-level lookup, 32-bit row then bit
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk)
    begin
        if (sys_rst)
        begin
            row_q <= '1;
            hit_q <= 1'b1;
        end
        else
        begin
            row_q <= flags_q[{i_rd_sn[9:5], 5'd0} +: 32];  // upper five bits pick row
            hit_q <= row_q[col_q];
        end
    end

    always_ff @(posedge sys_clk)
    begin
        col_q <= i_rd_sn[4:0];
    end

    assign o_timed_out = hit_q;

    a_set_wins: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (i_set && i_clr && (set_idx == clr_idx)) |=> flags_q[$past(set_idx)]);

endmodule

`default_nettype wire

// ==== source/wnd_ctrl.sv ====
// window manager control: reset delay, ram init sweep, ready gating, window size
`default_nettype none

module wnd_ctrl
    import nack_wnd_pkg::*;
#(
    parameter logic [15:0] MAX_WND_SIZE = 16'd4096
) (
    input  wire logic          sys_clk,
    input  wire logic          sys_rst,
    input  wire logic          i_cur_ready,
    input  wire logic          i_cfg_wnd_size_en,
    input  wire logic [15:0]   i_cfg_wnd_size,
    output logic               o_init_done,
    output logic [WND_AW-1:0]  o_init_addr,
    output logic               o_wnd_ready,
    output logic [15:0]        o_wnd_size
);

    localparam int DLY_W = $clog2(RST_DELAY);

    ctrl_state_e           state_q;
    logic [DLY_W-1:0]      dly_q;                   // reset settle counter
    logic [WND_AW-1:0]     addr_q;                  // sweep address
    logic [15:0]           wnd_size_q;

    //----------------------------------------------------------------------
    // init sequencer
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk)
    begin
        if (sys_rst)
        begin
            state_q <= ST_RST_WAIT;
            dly_q   <= '0;
            addr_q  <= '0;
        end
        else
        begin
            case (state_q)
                ST_RST_WAIT:
                begin
                    dly_q <= dly_q + 1'b1;
                    if (dly_q == DLY_W'(RST_DELAY - 1))
                        state_q <= ST_INIT;         // start the sweep
                end
                ST_INIT:
                begin
                    addr_q <= addr_q + 1'b1;        // one entry per cycle
                    if (addr_q == WND_AW'(WND_DEPTH - 1))
                        state_q <= ST_RUN;          // last entry written this edge
                end
                ST_RUN:  state_q <= ST_RUN;
                default: state_q <= ST_RST_WAIT;    // illegal code, redo init
            endcase
        end
    end

    assign o_init_done = (state_q == ST_RUN);
    assign o_init_addr = addr_q;
    assign o_wnd_ready = i_cur_ready & o_init_done; // no accepts during the sweep

    // override or default window size, reloaded every cycle
    always_ff @(posedge sys_clk)
    begin
        wnd_size_q <= i_cfg_wnd_size_en ? i_cfg_wnd_size : MAX_WND_SIZE;
    end

    assign o_wnd_size = wnd_size_q;

    // once running, only a reset brings the sequencer back
    a_run_sticky: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (state_q == ST_RUN) |=> (state_q == ST_RUN));

endmodule

`default_nettype wire

// ==== source/rpn_judge.sv ====
// rpn judge: wrap-aware new-packet decision for normal requests, two-cycle delay
`default_nettype none

module rpn_judge
    import nack_wnd_pkg::*;
(
    input  wire logic          sys_clk,
    input  wire logic          sys_rst,
    input  wire logic          i_valid,
    input  wire wnd_type_e     i_type,
    input  wire keymsg_t       i_keymsg,
    input  wire logic [15:0]   i_wnd_size,
    output logic               o_is_new
);

    logic [31:0] exp_rpn;
    logic [31:0] rpn;
    logic [31:0] w;
    logic [31:0] w_top;                             // all-ones minus w
    logic        judge;
    logic        new_c;
    logic [1:0]  new_q;

    assign exp_rpn = i_keymsg[63:32];
    assign rpn     = i_keymsg[31:0];
    assign w       = {16'd0, i_wnd_size};
    assign w_top   = ~w;

    always_comb
    begin
        if (rpn > exp_rpn)
            judge = !((exp_rpn < w) && (rpn > w_top));  // ahead, unless rpn wrapped back
        else if (rpn < exp_rpn)
            judge = (rpn < w) && (exp_rpn > w_top);     // behind, but rpn wrapped past zero
        else
            judge = 1'b0;                               // expected packet, nothing new
    end

    assign new_c = i_valid && (i_type == WND_NORMAL) && judge;

    // align with the ram and hitbox latency
    always_ff @(posedge sys_clk)
    begin
        if (sys_rst)
            new_q <= '0;
        else
            new_q <= {new_q[0], new_c};
    end

    assign o_is_new = new_q[1];

endmodule

`default_nettype wire

// ==== source/wnd_issue.sv ====
// window issue: two-stage request pipeline and window assembly with reset override
`default_nettype none

module wnd_issue
    import nack_wnd_pkg::*;
(
    input  wire logic      sys_clk,
    input  wire logic      sys_rst,
    input  wire logic      i_wnd_valid,             // accepted request
    input  wire sn_t       i_wnd_sn,
    input  wire chksum_t   i_wnd_chksum,
    input  wire keymsg_t   i_wnd_key_msg,
    input  wire wnd_type_e i_wnd_type,
    input  wire ptr_t      i_rd_hdr,                // ram data, already two cycles late
    input  wire ptr_t      i_rd_tail,
    input  wire logic      i_timed_out,
    input  wire logic      i_is_new,
    output ptr_t           o_cur_hdr,
    output ptr_t           o_cur_tail,
    output sn_t            o_cur_sn,
    output chksum_t        o_cur_chksum,
    output keymsg_t        o_cur_keymsg,
    output wnd_type_e      o_cur_type,
    output logic           o_cur_otsta,
    output logic           o_cur_valid
);

    sn_t       s1_sn,     s2_sn;
    chksum_t   s1_chksum, s2_chksum;
    keymsg_t   s1_key,    s2_key;
    wnd_type_e s1_type,   s2_type;
    logic      s1_vld,    s2_vld;
    logic      force_rst;

    //----------------------------------------------------------------------
    // request pipeline, never stalls
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk)
    begin
        s1_sn     <= i_wnd_sn;
        s1_chksum <= i_wnd_chksum;
        s1_key    <= i_wnd_key_msg;
        s1_type   <= i_wnd_type;
        s2_sn     <= s1_sn;
        s2_chksum <= s1_chksum;
        s2_key    <= s1_key;
        s2_type   <= s1_type;
    end

    always_ff @(posedge sys_clk)
    begin
        if (sys_rst)
        begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end
        else
        begin
            s1_vld <= i_wnd_valid;
            s2_vld <= s1_vld;
        end
    end

    //----------------------------------------------------------------------
    // assembly
    //----------------------------------------------------------------------
    assign force_rst    = i_timed_out & i_is_new;   // stale stream, fresh packet
    assign o_cur_hdr    = force_rst ? '0 : i_rd_hdr;
    assign o_cur_tail   = force_rst ? '0 : i_rd_tail;
    assign o_cur_type   = force_rst ? WND_RESET : s2_type;
    assign o_cur_sn     = s2_sn;
    assign o_cur_chksum = s2_chksum;
    assign o_cur_keymsg = s2_key;
    assign o_cur_otsta  = i_timed_out;
    assign o_cur_valid  = s2_vld;

    a_no_valid_in_rst: assert property (@(posedge sys_clk)
        sys_rst |=> !o_cur_valid);

endmodule

`default_nettype wire

// ==== source/nack_wnd_mgr.sv ====
// nack window manager top: pointer lookup, timeout check and window issue
`default_nettype none

module nack_wnd_mgr
    import nack_wnd_pkg::*;
#(
    parameter logic [15:0] MAX_WND_SIZE = 16'd4096     // window size without override
) (
    input  wire logic          sys_clk,
    input  wire logic          sys_rst,
    // request in
    input  wire sn_t           i_wnd_sn,
    input  wire chksum_t       i_wnd_chksum,
    input  wire keymsg_t       i_wnd_key_msg,
    input  wire wnd_type_e     i_wnd_type,
    input  wire logic          i_wnd_valid,
    output logic               o_wnd_ready,
    // issue to calculation core
    output ptr_t               o_cur_hdr,
    output ptr_t               o_cur_tail,
    output sn_t                o_cur_sn,
    output chksum_t            o_cur_chksum,
    output keymsg_t            o_cur_keymsg,
    output wnd_type_e          o_cur_type,
    output logic               o_cur_otsta,
    output logic               o_cur_valid,
    input  wire logic          i_cur_ready,
    // window update from calculation core
    input  wire sn_t           i_upd_sn,
    input  wire ptr_t          i_upd_hdr,
    input  wire ptr_t          i_upd_tail,
    input  wire logic          i_upd_valid,
    // timer side read
    input  wire sn_t           i_tmg_wnd_req_sn,
    input  wire logic          i_tmg_wnd_req_valid,
    output logic [63:0]        o_tmg_wnd,           // {hdr, tail}
    output logic               o_tmg_wnd_valid,
    // timer timeouts
    input  wire sn_t           i_timer_ot_sn,
    input  wire logic          i_timer_ot_vld,
    // configuration
    input  wire logic          i_cfg_wnd_size_en,
    input  wire logic [15:0]   i_cfg_wnd_size
);

    logic                  init_done;
    logic [WND_AW-1:0]     init_addr;
    logic [15:0]           wnd_size;
    logic                  wnd_accept;              // request handshake
    logic                  upd_clr;                 // update outside the sweep
    ptr_t                  lk_hdr;
    ptr_t                  lk_tail;
    logic                  timed_out;
    logic                  is_new;

    assign wnd_accept = i_wnd_valid & o_wnd_ready;
    assign upd_clr    = i_upd_valid & init_done;

    wnd_ctrl #(
        .MAX_WND_SIZE (MAX_WND_SIZE)
    ) u_ctrl (
        .sys_clk           (sys_clk),
        .sys_rst           (sys_rst),
        .i_cur_ready       (i_cur_ready),
        .i_cfg_wnd_size_en (i_cfg_wnd_size_en),
        .i_cfg_wnd_size    (i_cfg_wnd_size),
        .o_init_done       (init_done),
        .o_init_addr       (init_addr),
        .o_wnd_ready       (o_wnd_ready),
        .o_wnd_size        (wnd_size)
    );

    //----------------------------------------------------------------------
    // two pointer ram copies, one per read port
    //----------------------------------------------------------------------
    wnd_ptr_ram u_ram_lookup (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .i_init_done (init_done),
        .i_init_addr (init_addr),
        .i_wr_en     (i_upd_valid),
        .i_wr_addr   (i_upd_sn[WND_AW-1:0]),
        .i_wr_hdr    (i_upd_hdr),
        .i_wr_tail   (i_upd_tail),
        .i_rd_valid  (wnd_accept),
        .i_rd_addr   (i_wnd_sn[WND_AW-1:0]),
        .o_rd_valid  (),                            // issue valid tracked in wnd_issue
        .o_rd_hdr    (lk_hdr),
        .o_rd_tail   (lk_tail)
    );

    wnd_ptr_ram u_ram_timer (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .i_init_done (init_done),
        .i_init_addr (init_addr),
        .i_wr_en     (i_upd_valid),
        .i_wr_addr   (i_upd_sn[WND_AW-1:0]),
        .i_wr_hdr    (i_upd_hdr),
        .i_wr_tail   (i_upd_tail),
        .i_rd_valid  (i_tmg_wnd_req_valid),
        .i_rd_addr   (i_tmg_wnd_req_sn[WND_AW-1:0]),
        .o_rd_valid  (o_tmg_wnd_valid),
        .o_rd_hdr    (o_tmg_wnd[63:32]),
        .o_rd_tail   (o_tmg_wnd[31:0])
    );

    ot_hitbox u_hitbox (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .i_set       (i_timer_ot_vld),
        .i_set_sn    (i_timer_ot_sn),
        .i_clr       (upd_clr),
        .i_clr_sn    (i_upd_sn),
        .i_rd_sn     (i_wnd_sn),
        .o_timed_out (timed_out)
    );

    rpn_judge u_judge (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .i_valid    (wnd_accept),
        .i_type     (i_wnd_type),
        .i_keymsg   (i_wnd_key_msg),
        .i_wnd_size (wnd_size),
        .o_is_new   (is_new)
    );

    wnd_issue u_issue (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .i_wnd_valid   (wnd_accept),
        .i_wnd_sn      (i_wnd_sn),
        .i_wnd_chksum  (i_wnd_chksum),
        .i_wnd_key_msg (i_wnd_key_msg),
        .i_wnd_type    (i_wnd_type),
        .i_rd_hdr      (lk_hdr),
        .i_rd_tail     (lk_tail),
        .i_timed_out   (timed_out),
        .i_is_new      (is_new),
        .o_cur_hdr     (o_cur_hdr),
        .o_cur_tail    (o_cur_tail),
        .o_cur_sn      (o_cur_sn),
        .o_cur_chksum  (o_cur_chksum),
        .o_cur_keymsg  (o_cur_keymsg),
        .o_cur_type    (o_cur_type),
        .o_cur_otsta   (o_cur_otsta),
        .o_cur_valid   (o_cur_valid)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
// testbench clock and reset source for the window manager bench
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 40,                  // full clock period
    parameter int RST_CYCLES = 10                   // reset length in clocks
) (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;    // free running
    end

    initial
    begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;                              // release on an edge
    end

endmodule

`default_nettype wire

// ==== dv/tb_nack_wnd_mgr.sv ====
// window manager testbench with random traffic checked against a stream model
`default_nettype none

module tb_nack_wnd_mgr
    import nack_wnd_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] DEF_WND  = 16'd4096;    // window size without override
    localparam int          LOOP_MAX = 4000;        // cycles any wait may take
    localparam int          GAP      = 3;           // spacing between write and lookup

    typedef struct packed {
        int          due;                           // cycle the issue must appear
        ptr_t        hdr;
        ptr_t        tail;
        sn_t         sn;
        chksum_t     chk;
        keymsg_t     key;
        logic [1:0]  typ;
        logic        ot;
    } issue_t;

    typedef struct packed {
        int          due;
        logic [63:0] wnd;                           // {hdr, tail}
    } tmg_t;

    logic        sys_clk;
    logic        sys_rst;
    sn_t         i_wnd_sn;
    chksum_t     i_wnd_chksum;
    keymsg_t     i_wnd_key_msg;
    wnd_type_e   i_wnd_type;
    logic        i_wnd_valid;
    logic        o_wnd_ready;
    ptr_t        o_cur_hdr;
    ptr_t        o_cur_tail;
    sn_t         o_cur_sn;
    chksum_t     o_cur_chksum;
    keymsg_t     o_cur_keymsg;
    wnd_type_e   o_cur_type;
    logic        o_cur_otsta;
    logic        o_cur_valid;
    logic        i_cur_ready;
    sn_t         i_upd_sn;
    ptr_t        i_upd_hdr;
    ptr_t        i_upd_tail;
    logic        i_upd_valid;
    sn_t         i_tmg_wnd_req_sn;
    logic        i_tmg_wnd_req_valid;
    logic [63:0] o_tmg_wnd;
    logic        o_tmg_wnd_valid;
    sn_t         i_timer_ot_sn;
    logic        i_timer_ot_vld;
    logic        i_cfg_wnd_size_en;
    logic [15:0] i_cfg_wnd_size;

    //----------------------------------------------------------------------
    // stream model and bookkeeping
    //----------------------------------------------------------------------
    ptr_t        hdr_m  [WND_DEPTH];
    ptr_t        tail_m [WND_DEPTH];
    logic        ot_m   [WND_DEPTH];                // 1 = timed out
    int          last_rd [WND_DEPTH];               // cycle of last lookup
    int          last_wr [WND_DEPTH];               // cycle of last update or timeout
    logic [15:0] wnd_m;                             // window size the judge uses
    logic        run_m;                             // sweep finished, requests allowed
    issue_t      exp_q [$];
    tmg_t        tmg_q [$];
    int          cyc;
    int          err_cnt;
    int          tmo_cnt;
    int          n;
    logic [31:0] lfsr_q;

    tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(10)) u_clkgen (.o_clk(sys_clk), .o_rst(sys_rst));

    nack_wnd_mgr #(.MAX_WND_SIZE(DEF_WND)) dut0 (.*);

    // galois lfsr stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] v;
        int          b;
        v = '0;
        for (b = 0; b < nbits; b++)
        begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // wrap-aware new packet rule around both ends of the rpn space
    function automatic logic rpn_is_new(input logic [31:0] expv, input logic [31:0] rpn,
                                        input logic [31:0] w);
        logic [31:0] top;
        top = 32'hffff_ffff - w;
        if (rpn == expv)
            return 1'b0;
        if (rpn > expv)
            return !((expv < w) && (rpn > top));    // far ahead means rpn wrapped back
        return (rpn < w) && (expv > top);           // behind only across zero
    endfunction

    function automatic logic [WND_AW-1:0] pool_sn();
        logic [31:0] r;
        r = take_bits(6);
        return {4'b1011, r[5:0]};                   // small pool so streams get reused
    endfunction

    task automatic check(input logic [95:0] got, input logic [95:0] exp, input string what);
        if (got !== exp)
        begin
            err_cnt++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        if (exp_q.size() != 0 || tmg_q.size() != 0)
        begin
            err_cnt++;
            $display("expected outputs never appeared before the end of the run");
        end
        $display("checks done: %0d value errors, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    //----------------------------------------------------------------------
    // one clock of prediction from the driven inputs and checks after the edge
    //----------------------------------------------------------------------
    task automatic step();
        issue_t            it;
        tmg_t              tr;
        logic [WND_AW-1:0] idx;
        logic              frc;
        logic              rdy;
        #1;                                         // ready is combinational
        rdy = (i_cur_ready === 1'b1) && run_m;
        check(o_wnd_ready, rdy, "o_wnd_ready");
        if (i_wnd_valid && rdy)
        begin
            idx    = i_wnd_sn[WND_AW-1:0];
            frc    = ot_m[idx] && (i_wnd_type == WND_NORMAL)
                     && rpn_is_new(i_wnd_key_msg[63:32], i_wnd_key_msg[31:0], {16'd0, wnd_m});
            it.due  = cyc + 2;
            it.hdr  = frc ? '0 : hdr_m[idx];        // stale stream restarts at zero
            it.tail = frc ? '0 : tail_m[idx];
            it.sn   = i_wnd_sn;
            it.chk  = i_wnd_chksum;
            it.key  = i_wnd_key_msg;
            it.typ  = frc ? WND_RESET : i_wnd_type;
            it.ot   = ot_m[idx];
            exp_q.push_back(it);
        end
        if (i_tmg_wnd_req_valid)
        begin
            idx    = i_tmg_wnd_req_sn[WND_AW-1:0];
            tr.due = cyc + 2;
            tr.wnd = {hdr_m[idx], tail_m[idx]};
            tmg_q.push_back(tr);
        end
        if (i_upd_valid)                            // writes land after the reads
        begin
            idx         = i_upd_sn[WND_AW-1:0];
            hdr_m[idx]  = i_upd_hdr;
            tail_m[idx] = i_upd_tail;
            ot_m[idx]   = 1'b0;
        end
        if (i_timer_ot_vld)
            ot_m[i_timer_ot_sn[WND_AW-1:0]] = 1'b1; // timeout beats a same-cycle update
        @(negedge sys_clk);
        cyc++;
        if (exp_q.size() != 0 && exp_q[0].due == cyc)
        begin
            it = exp_q.pop_front();
            check(o_cur_valid, 1'b1, "o_cur_valid");
            check(o_cur_hdr, it.hdr, "o_cur_hdr");
            check(o_cur_tail, it.tail, "o_cur_tail");
            check(o_cur_sn, it.sn, "o_cur_sn");
            check(o_cur_chksum, it.chk, "o_cur_chksum");
            check(o_cur_keymsg, it.key, "o_cur_keymsg");
            check(o_cur_type, it.typ, "o_cur_type");
            check(o_cur_otsta, it.ot, "o_cur_otsta");
        end
        else
            check(o_cur_valid, 1'b0, "o_cur_valid");
        if (tmg_q.size() != 0 && tmg_q[0].due == cyc)
        begin
            tr = tmg_q.pop_front();
            check(o_tmg_wnd_valid, 1'b1, "o_tmg_wnd_valid");
            check(o_tmg_wnd, tr.wnd, "o_tmg_wnd");
        end
        else
            check(o_tmg_wnd_valid, 1'b0, "o_tmg_wnd_valid");
        i_wnd_valid         = 1'b0;                 // strobes last one cycle
        i_upd_valid         = 1'b0;
        i_tmg_wnd_req_valid = 1'b0;
        i_timer_ot_vld      = 1'b0;
    endtask

    //----------------------------------------------------------------------
    // drivers called on the falling edge
    //----------------------------------------------------------------------
    task automatic drive_lookup(input logic [WND_AW-1:0] idx, input wnd_type_e typ,
                                input logic [31:0] expv, input logic [31:0] rpn);
        logic [31:0] r;
        r             = take_bits(6);
        i_wnd_sn      = {r[5:0], idx};              // upper sn bits ride along
        i_wnd_chksum  = take_bits(32);
        i_wnd_key_msg = {take_bits(32), expv, rpn};
        i_wnd_type    = typ;
        i_wnd_valid   = 1'b1;
        last_rd[idx]  = cyc;
    endtask

    task automatic drive_random_lookup(input logic [WND_AW-1:0] idx);
        logic [31:0] expv;
        logic [31:0] rpn;
        case (take_bits(2))
            2'd0:
            begin
                expv = take_bits(32);
                rpn  = take_bits(32);
            end
            2'd1:
            begin
                expv = take_bits(13);               // expected near zero and rpn near top
                rpn  = ~take_bits(13);
            end
            2'd2:
            begin
                expv = ~take_bits(13);
                rpn  = take_bits(13);               // rpn wrapped past zero
            end
            default:
            begin
                expv = take_bits(32);
                rpn  = (take_bits(3) == 0) ? expv : expv + take_bits(14) - 32'd8192;
            end
        endcase
        drive_lookup(idx, (take_bits(2) == 0) ? WND_NACK_REPLY : WND_NORMAL, expv, rpn);
    endtask

    task automatic drive_update(input logic [WND_AW-1:0] idx);
        logic [31:0] r;
        r            = take_bits(6);
        i_upd_sn     = {r[5:0], idx};
        i_upd_hdr    = take_bits(32);
        i_upd_tail   = take_bits(32);
        i_upd_valid  = 1'b1;
        last_wr[idx] = cyc;
    endtask

    task automatic drive_timeout(input logic [WND_AW-1:0] idx);
        i_timer_ot_sn  = {6'd0, idx};
        i_timer_ot_vld = 1'b1;
        last_wr[idx]   = cyc;
    endtask

    task automatic drive_timer_read(input logic [WND_AW-1:0] idx);
        i_tmg_wnd_req_sn    = {6'd0, idx};
        i_tmg_wnd_req_valid = 1'b1;
    endtask

    // update, lookup, timer read, timeout and lookup again on one stream
    task automatic directed_windows(input int count);
        logic [31:0] r;
        logic [WND_AW-1:0] idx;
        repeat (count)
        begin
            r   = take_bits(10);
            idx = r[WND_AW-1:0];
            drive_lookup(idx, WND_NORMAL, 32'd100, 32'd200);
            repeat (GAP + 2) step();
            drive_update(idx);
            repeat (GAP + 2) step();
            drive_lookup(idx, WND_NORMAL, 32'd100, 32'd200);
            drive_timer_read(idx);
            repeat (GAP + 2) step();
            drive_timeout(idx);
            repeat (GAP + 2) step();
            drive_lookup(idx, WND_NORMAL, 32'd100, 32'd200);        // forced reset
            step();
            drive_lookup(idx, WND_NACK_REPLY, 32'd100, 32'd200);    // keeps its type
            step();
            drive_lookup(idx, WND_NORMAL, 32'd200, 32'd100);        // old packet
            step();
        end
    endtask

    task automatic random_traffic(input int count);
        logic [WND_AW-1:0] idx;
        repeat (count)
        begin
            i_cur_ready = (take_bits(3) != 0);      // core busy one cycle in eight
            idx = pool_sn();
            if (take_bits(1) && (cyc - last_wr[idx] > GAP))
                drive_random_lookup(idx);
            idx = pool_sn();
            if (take_bits(2) == 0 && (cyc - last_rd[idx] > GAP))
                drive_update(idx);
            idx = pool_sn();
            if (take_bits(3) == 0 && (cyc - last_rd[idx] > GAP))
                drive_timeout(idx);
            if (take_bits(2) == 0)
                drive_timer_read(pool_sn());
            step();
        end
        i_cur_ready = 1'b1;
    endtask

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial
    begin
        i_wnd_sn            = '0;
        i_wnd_chksum        = '0;
        i_wnd_key_msg       = '0;
        i_wnd_type          = WND_NORMAL;
        i_wnd_valid         = 1'b0;
        i_cur_ready         = 1'b0;
        i_upd_sn            = '0;
        i_upd_hdr           = '0;
        i_upd_tail          = '0;
        i_upd_valid         = 1'b0;
        i_tmg_wnd_req_sn    = '0;
        i_tmg_wnd_req_valid = 1'b0;
        i_timer_ot_sn       = '0;
        i_timer_ot_vld      = 1'b0;
        i_cfg_wnd_size_en   = 1'b0;
        i_cfg_wnd_size      = '0;
        for (n = 0; n < WND_DEPTH; n++)
        begin
            hdr_m[n]   = '0;
            tail_m[n]  = '0;
            ot_m[n]    = 1'b1;                      // all streams start timed out
            last_rd[n] = -100;
            last_wr[n] = -100;
        end
        wnd_m   = DEF_WND;
        run_m   = 1'b0;
        lfsr_q  = 32'ha1bb;
        cyc     = 0;
        err_cnt = 0;
        tmo_cnt = 0;

        n = 0;
        while (sys_rst !== 1'b0 && n < LOOP_MAX)
        begin
            @(negedge sys_clk);
            n++;
        end
        if (sys_rst !== 1'b0)
        begin
            tmo_cnt++;
            $display("timeout: reset was never released");
        end
        else
        begin
            // requests knock during the sweep and none may be taken
            i_cur_ready = 1'b1;
            n = 0;
            while (o_wnd_ready !== 1'b1 && n < LOOP_MAX)
            begin
                drive_random_lookup(pool_sn());
                step();
                n++;
            end
            if (o_wnd_ready !== 1'b1)
            begin
                tmo_cnt++;
                $display("timeout: o_wnd_ready never rose after the ram sweep");
            end
            else
            begin
                run_m = 1'b1;
                check(n >= WND_DEPTH, 1'b1, "ready before 1024 sweep cycles");

                directed_windows(16);
                random_traffic(800);

                i_cfg_wnd_size_en = 1'b1;           // configured window size
                i_cfg_wnd_size    = 16'(take_bits(16));
                wnd_m             = i_cfg_wnd_size;
                repeat (GAP) step();
                random_traffic(800);

                i_cfg_wnd_size_en = 1'b0;
                wnd_m             = DEF_WND;
                repeat (GAP) step();
                random_traffic(200);

                repeat (GAP + 2) step();            // drain the pipeline
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/nack_wnd_pkg.sv
wnd_store/wnd_ptr_ram.sv
wnd_store/ot_hitbox.sv
source/wnd_ctrl.sv
source/rpn_judge.sv
source/wnd_issue.sv
source/nack_wnd_mgr.sv
dv/tb_clkgen.sv
dv/tb_nack_wnd_mgr.sv

// ==== Bender.yml ====
package:
  name: nack_wnd_mgr

sources:
  - common/nack_wnd_pkg.sv
  - wnd_store/wnd_ptr_ram.sv
  - wnd_store/ot_hitbox.sv
  - source/wnd_ctrl.sv
  - source/rpn_judge.sv
  - source/wnd_issue.sv
  - source/nack_wnd_mgr.sv
  - target: test
    files:
      - dv/tb_clkgen.sv
      - dv/tb_nack_wnd_mgr.sv
